//--- tb.f
common/pcore_isa_pkg.sv
common/pcore_pipe_pkg.sv
hw/mem_stage.sv
hw/data_mem.sv
hw/csr_file.sv
writeback/writeback.sv
writeback/reg_file.sv
hw/pcore_backend.sv
bench/backend_chk.sv
bench/tb_backend.sv

//--- bench/tb_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_backend;

    import pcore_isa_pkg::*;
    import pcore_pipe_pkg::*;

    localparam int unsigned DMEM_DEPTH = 256;
    localparam int          WAIT_LIMIT = 50;
    localparam int          NREG       = 2 ** REG_AW;

    // One expected writeback, due is the cycle count at the checking edge
    typedef struct packed {
        logic [31:0]       due;
        logic              wr;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } wb_exp_t;

    logic              clk;
    logic              rst_n_i;
    logic              op_req_i;
    logic              op_ack_o;
    exe_op_e           op_code_i;
    logic [REG_AW-1:0] rd_addr_i;
    logic [XLEN-1:0]   alu_result_i;
    logic [XLEN-1:0]   pc_next_i;
    logic [XLEN-1:0]   wr_data_i;
    logic [CSR_AW-1:0] csr_addr_i;
    logic              rd_wr_o;
    logic [REG_AW-1:0] rd_addr_o;
    logic [XLEN-1:0]   rd_data_o;
    logic [REG_AW-1:0] rs_addr_i;
    logic [XLEN-1:0]   rs_data_o;

    // Architectural model
    logic [XLEN-1:0]   reg_m [NREG];
    logic [XLEN-1:0]   mem_m [DMEM_DEPTH];
    logic [XLEN-1:0]   mscratch_m;
    logic [XLEN-1:0]   mtvec_m;
    logic [XLEN-1:0]   mepc_m;

    wb_exp_t           exp_q [$];
    int                cyc = 0;
    int                err_cnt = 0;
    int                fwd_cnt = 0;
    int                test_num = 0;
    int                tests_failed = 0;
    int                test_err_base = 0;
    integer            seed;

    pcore_backend #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) UUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .op_req_i     (op_req_i),
        .op_ack_o     (op_ack_o),
        .op_code_i    (op_code_i),
        .rd_addr_i    (rd_addr_i),
        .alu_result_i (alu_result_i),
        .pc_next_i    (pc_next_i),
        .wr_data_i    (wr_data_i),
        .csr_addr_i   (csr_addr_i),
        .rd_wr_o      (rd_wr_o),
        .rd_addr_o    (rd_addr_o),
        .rd_data_o    (rd_data_o),
        .rs_addr_i    (rs_addr_i),
        .rs_data_o    (rs_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Applies one operation to the model and returns the value bound for rd
    function automatic logic [XLEN-1:0] ref_writeback(
        input  exe_op_e           op,
        input  logic [REG_AW-1:0] rd,
        input  logic [XLEN-1:0]   alu,
        input  logic [XLEN-1:0]   pcn,
        input  logic [XLEN-1:0]   wdata,
        input  logic [CSR_AW-1:0] csr,
        output logic              wr
    );
        int unsigned     widx;
        logic [XLEN-1:0] res;
        widx = (alu >> 2) % DMEM_DEPTH;
        res  = '0;
        case (op)
            OP_ALU   : res = alu;
            OP_LINK  : res = pcn;
            OP_LOAD  : res = mem_m[widx];
            OP_STORE : mem_m[widx] = wdata;
            OP_CSRRW : begin
                case (csr)
                    CSR_MSCRATCH : begin
                        res        = mscratch_m;
                        mscratch_m = wdata;
                    end
                    CSR_MTVEC : begin
                        res     = mtvec_m;
                        mtvec_m = wdata;
                    end
                    CSR_MEPC : begin
                        res    = mepc_m;
                        mepc_m = wdata;
                    end
                    default : res = '0;
                endcase
            end
            default : res = '0;
        endcase
        wr = (op != OP_STORE) && (rd != '0);
        if (wr) begin
            reg_m[rd] = res;
        end
        return res;
    endfunction

    function automatic int total_errors();
        return err_cnt + UUT.u_backend_chk.fail_cnt;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s within %0d cycles", what, WAIT_LIMIT);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic check_wb(input logic exp_wr, input logic [REG_AW-1:0] exp_addr,
                            input logic [XLEN-1:0] exp_data);
        if (rd_wr_o !== exp_wr) begin
            $display("MISMATCH rd_wr_o: got %h expected %h", rd_wr_o, exp_wr);
            err_cnt++;
        end else if (exp_wr) begin
            if (rd_addr_o !== exp_addr) begin
                $display("MISMATCH rd_addr_o: got %h expected %h", rd_addr_o, exp_addr);
                err_cnt++;
            end
            if (rd_data_o !== exp_data) begin
                $display("MISMATCH rd_data_o: got %h expected %h", rd_data_o, exp_data);
                err_cnt++;
            end
        end
    endtask

    task automatic check_xlen(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Pre-edge values, inputs only move on the falling edge
    always @(posedge clk) begin
        if (rst_n_i) begin
            if ((exp_q.size() != 0) && (exp_q[0].due == cyc)) begin
                check_wb(exp_q[0].wr, exp_q[0].addr, exp_q[0].data);
                if (exp_q[0].wr && (rs_addr_i == exp_q[0].addr)) begin
                    check_xlen("rs_data_o (bypass)", rs_data_o, exp_q[0].data);
                    fwd_cnt++;
                end
                void'(exp_q.pop_front());
            end else begin
                check_wb(1'b0, '0, '0);
            end
        end
        cyc = cyc + 1;
    end

    // Four-phase request, called and returning on a falling edge
    task automatic issue_op(input exe_op_e op, input logic [REG_AW-1:0] rd,
                            input logic [XLEN-1:0] alu, input logic [XLEN-1:0] pcn,
                            input logic [XLEN-1:0] wdata, input logic [CSR_AW-1:0] csr,
                            input logic [REG_AW-1:0] rs);
        wb_exp_t e;
        logic    wr;
        int      waited;
        waited = 0;
        while (op_ack_o) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("op_ack_o did not return low");
            @(negedge clk);
        end
        op_code_i    = op;
        rd_addr_i    = rd;
        alu_result_i = alu;
        pc_next_i    = pcn;
        wr_data_i    = wdata;
        csr_addr_i   = csr;
        rs_addr_i    = rs;
        op_req_i     = 1'b1;
        waited       = 0;
        @(negedge clk);
        while (!op_ack_o) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("op_ack_o did not answer a request");
            @(negedge clk);
        end
        // Ack is due on the first edge that sees the request
        if (waited != 0) begin
            $display("op_ack_o rose %0d cycles later than the first edge of op_req_i",
                     waited);
            err_cnt++;
        end
        e.data = ref_writeback(op, rd, alu, pcn, wdata, csr, wr);
        e.wr   = wr;
        e.addr = rd;
        e.due  = cyc + 1;
        exp_q.push_back(e);
        op_req_i = 1'b0;
        @(negedge clk);
        if (op_ack_o) begin
            $display("op_ack_o still high one edge after op_req_i dropped");
            err_cnt++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("writeback did not complete");
            @(negedge clk);
        end
    endtask

    task automatic check_reg(input logic [REG_AW-1:0] r);
        rs_addr_i = r;
        @(posedge clk);
        check_xlen($sformatf("rs_data_o[x%0d]", r), rs_data_o, reg_m[r]);
        @(negedge clk);
    endtask

    task automatic issue_random_op();
        exe_op_e           op;
        logic [XLEN-1:0]   alu;
        logic [CSR_AW-1:0] csr;
        logic [31:0]       rnd_rd;
        logic [31:0]       rnd_rs;
        op  = exe_op_e'({$random(seed)} % 5);
        alu = $random(seed);
        // Random upper bits wrap the index, loads stay within the filled words
        if ((op == OP_LOAD) || (op == OP_STORE)) begin
            alu = (alu & ~((DMEM_DEPTH * 4) - 1)) | (({$random(seed)} % 16) << 2);
        end
        case ({$random(seed)} % 4)
            0       : csr = CSR_MSCRATCH;
            1       : csr = CSR_MTVEC;
            2       : csr = CSR_MEPC;
            default : csr = 12'h7c0;
        endcase
        rnd_rd = $random(seed);
        rnd_rs = $random(seed);
        issue_op(op, rnd_rd[REG_AW-1:0], alu, $random(seed), $random(seed), csr,
                 rnd_rs[REG_AW-1:0]);
    endtask

    task automatic start_test();
        test_err_base = total_errors();
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = total_errors() - test_err_base;
        test_num++;
        if (errs == 0) begin
            $display("test %0d %s: PASS", test_num, name);
        end else begin
            $display("test %0d %s: FAIL with %0d errors", test_num, name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        int fwd_base;
        seed         = 32'hb1266e6c;
        rst_n_i      = 1'b0;
        op_req_i     = 1'b0;
        op_code_i    = OP_ALU;
        rd_addr_i    = '0;
        alu_result_i = '0;
        pc_next_i    = '0;
        wr_data_i    = '0;
        csr_addr_i   = '0;
        rs_addr_i    = '0;
        mscratch_m   = '0;
        mtvec_m      = '0;
        mepc_m       = '0;
        for (int i = 0; i < NREG; i++) begin
            reg_m[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        start_test();
        issue_op(OP_ALU, 5'd5, 32'h1234_5678, 32'h0000_0104, 32'h0, 12'h0, 5'd0);
        issue_op(OP_LINK, 5'd6, 32'hdead_beef, 32'h0000_2008, 32'h0, 12'h0, 5'd0);
        drain();
        check_reg(5'd5);
        check_reg(5'd6);
        end_test("alu_and_link");

        start_test();
        issue_op(OP_STORE, 5'd7, 32'h0000_0040, 32'h0, 32'hcafe_0001, 12'h0, 5'd0);
        issue_op(OP_LOAD, 5'd8, 32'h0000_0040 + DMEM_DEPTH * 4, 32'h0, 32'h0, 12'h0, 5'd0);
        issue_op(OP_STORE, 5'd0, 32'hffff_fffc, 32'h0, 32'ha5a5_0002, 12'h0, 5'd0);
        issue_op(OP_LOAD, 5'd9, (DMEM_DEPTH - 1) * 4, 32'h0, 32'h0, 12'h0, 5'd0);
        drain();
        check_reg(5'd8);
        check_reg(5'd9);
        end_test("store_load_wrap");

        start_test();
        issue_op(OP_CSRRW, 5'd10, 32'h0, 32'h0, 32'h0000_1111, CSR_MSCRATCH, 5'd0);
        issue_op(OP_CSRRW, 5'd11, 32'h0, 32'h0, 32'h0000_2222, CSR_MSCRATCH, 5'd0);
        issue_op(OP_CSRRW, 5'd12, 32'h0, 32'h0, 32'h0000_3333, CSR_MTVEC, 5'd0);
        issue_op(OP_CSRRW, 5'd13, 32'h0, 32'h0, 32'h0000_4444, CSR_MEPC, 5'd0);
        issue_op(OP_CSRRW, 5'd14, 32'h0, 32'h0, 32'h0000_5555, CSR_MEPC, 5'd0);
        issue_op(OP_CSRRW, 5'd15, 32'h0, 32'h0, 32'h0000_6666, 12'h7c0, 5'd0);
        issue_op(OP_CSRRW, 5'd16, 32'h0, 32'h0, 32'h0000_7777, 12'h7c0, 5'd0);
        drain();
        for (int r = 10; r <= 16; r++) begin
            check_reg(REG_AW'(r));
        end
        end_test("csr_swap");

        start_test();
        issue_op(OP_ALU, 5'd0, 32'hffff_ffff, 32'h0, 32'h0, 12'h0, 5'd0);
        issue_op(OP_LOAD, 5'd0, 32'h0000_0040, 32'h0, 32'h0, 12'h0, 5'd0);
        issue_op(OP_CSRRW, 5'd0, 32'h0, 32'h0, 32'h0000_8888, CSR_MTVEC, 5'd0);
        drain();
        check_reg(5'd0);
        check_xlen("rs_data_o[x0]", rs_data_o, 32'h0);
        end_test("x0_destination");

        start_test();
        fwd_base = fwd_cnt;
        issue_op(OP_ALU, 5'd9, 32'h0bad_f00d, 32'h0, 32'h0, 12'h0, 5'd9);
        issue_op(OP_LINK, 5'd9, 32'h0, 32'h0000_3004, 32'h0, 12'h0, 5'd9);
        drain();
        if (fwd_cnt - fwd_base != 2) begin
            $display("Forwarding path was not sampled during the writeback cycles");
            err_cnt++;
        end
        check_reg(5'd9);
        end_test("read_forwarding");

        start_test();
        for (int w = 0; w < 16; w++) begin
            issue_op(OP_STORE, 5'd0, w * 4, 32'h0, $random(seed), 12'h0, 5'd0);
        end
        repeat (200) begin
            issue_random_op();
        end
        drain();
        for (int r = 0; r < NREG; r++) begin
            check_reg(REG_AW'(r));
        end
        end_test("random_mix");

        $display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
                 test_num, test_num - tests_failed, tests_failed, err_cnt,
                 UUT.u_backend_chk.fail_cnt);
        if (total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_backend

`default_nettype wire

//--- bench/backend_chk.sv
`timescale 1ns/1ps
`default_nettype none

module backend_chk (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               op_req_i,
    input  logic                               op_ack_i,
    input  pcore_isa_pkg::exe_op_e             op_code_i,
    input  logic [pcore_pipe_pkg::REG_AW-1:0]  issue_rd_i,
    input  logic                               rd_wr_i,
    input  logic [pcore_pipe_pkg::REG_AW-1:0]  rd_addr_i
);

    import pcore_isa_pkg::*;

    int unsigned fail_cnt = 0;
    logic        issue_store;

    // Store accepted on this edge, it reaches writeback two edges later
    assign issue_store = op_req_i && !op_ack_i && (op_code_i == OP_STORE);

    // Four-phase handshake, ack only drops once the request is gone
    ack_release: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(op_ack_i) |-> !$past(op_req_i))
        else begin
            $error("op_ack_o fell while op_req_i was still high");
            fail_cnt++;
        end

    // x0 is never a write target, and the target is the register that was issued
    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_wr_i |-> (rd_addr_i != '0) && (rd_addr_i == $past(issue_rd_i, 2)))
        else begin
            $error("rd_wr_o raised for x0 or for a register other than the one issued");
            fail_cnt++;
        end

    no_store_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_wr_i |-> !$past(issue_store, 2))
        else begin
            $error("rd_wr_o raised for a store");
            fail_cnt++;
        end

endmodule : backend_chk

// Sees the issue handshake and the writeback request where the top joins them
bind pcore_backend backend_chk u_backend_chk (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .op_req_i   (op_req_i),
    .op_ack_i   (op_ack_o),
    .op_code_i  (op_code_i),
    .issue_rd_i (rd_addr_i),
    .rd_wr_i    (rd_wr_o),
    .rd_addr_i  (rd_addr_o)
);

`default_nettype wire

//--- hw/pcore_backend.sv
`timescale 1ns/1ps
`default_nettype none

module pcore_backend #(
    parameter int unsigned DMEM_DEPTH = 256
) (
    input  logic                                clk,
    input  logic                                rst_n_i,

    input  logic                                op_req_i,
    output logic                                op_ack_o,
    input  pcore_isa_pkg::exe_op_e              op_code_i,
    input  logic [pcore_pipe_pkg::REG_AW-1:0]   rd_addr_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      alu_result_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      pc_next_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      wr_data_i,
    input  logic [pcore_isa_pkg::CSR_AW-1:0]    csr_addr_i,

    output logic                                rd_wr_o,
    output logic [pcore_pipe_pkg::REG_AW-1:0]   rd_addr_o,
    output logic [pcore_isa_pkg::XLEN-1:0]      rd_data_o,

    input  logic [pcore_pipe_pkg::REG_AW-1:0]   rs_addr_i,
    output logic [pcore_isa_pkg::XLEN-1:0]      rs_data_o
);

    import pcore_isa_pkg::*;
    import pcore_pipe_pkg::*;

    localparam int unsigned DMEM_AW = $clog2(DMEM_DEPTH);

    logic                 dmem_we;
    logic [DMEM_AW-1:0]   dmem_addr;
    logic [XLEN-1:0]      dmem_wdata;
    logic [XLEN-1:0]      dmem_rdata;

    logic                 csr_we;
    logic [CSR_AW-1:0]    csr_addr;
    logic [XLEN-1:0]      csr_wdata;
    logic [XLEN-1:0]      csr_rdata;

    logic                 wb_valid;
    rd_wrb_sel_e          wb_sel;
    logic [REG_AW-1:0]    wb_rd_addr;
    logic [XLEN-1:0]      wb_alu_result;
    logic [XLEN-1:0]      wb_pc_next;
    logic                 wb_is_store;

    mem_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_mem_stage (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .op_req_i        (op_req_i),
        .op_ack_o        (op_ack_o),
        .op_code_i       (op_code_i),
        .rd_addr_i       (rd_addr_i),
        .alu_result_i    (alu_result_i),
        .pc_next_i       (pc_next_i),
        .wr_data_i       (wr_data_i),
        .csr_addr_i      (csr_addr_i),
        .dmem_we_o       (dmem_we),
        .dmem_addr_o     (dmem_addr),
        .dmem_wdata_o    (dmem_wdata),
        .csr_we_o        (csr_we),
        .csr_addr_o      (csr_addr),
        .csr_wdata_o     (csr_wdata),
        .wb_valid_o      (wb_valid),
        .wb_sel_o        (wb_sel),
        .wb_rd_addr_o    (wb_rd_addr),
        .wb_alu_result_o (wb_alu_result),
        .wb_pc_next_o    (wb_pc_next),
        .wb_is_store_o   (wb_is_store)
    );

    data_mem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_data_mem (
        .clk     (clk),
        .we_i    (dmem_we),
        .addr_i  (dmem_addr),
        .wdata_i (dmem_wdata),
        .rdata_o (dmem_rdata)
    );

    csr_file u_csr_file (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (csr_we),
        .addr_i  (csr_addr),
        .wdata_i (csr_wdata),
        .rdata_o (csr_rdata)
    );

    writeback u_writeback (
        .wb_valid_i    (wb_valid),
        .wb_sel_i      (wb_sel),
        .wb_rd_addr_i  (wb_rd_addr),
        .wb_is_store_i (wb_is_store),
        .alu_result_i  (wb_alu_result),
        .pc_next_i     (wb_pc_next),
        .dmem_rdata_i  (dmem_rdata),
        .csr_rdata_i   (csr_rdata),
        .rd_wr_o       (rd_wr_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o)
    );

    // Write port and bypass compare both take the writeback request
    reg_file u_reg_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_i      (rd_wr_o),
        .wr_addr_i (rd_addr_o),
        .wr_data_i (rd_data_o),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o)
    );

endmodule : pcore_backend

`default_nettype wire

//--- writeback/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                wr_i,
    input  logic [pcore_pipe_pkg::REG_AW-1:0]   wr_addr_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      wr_data_i,
    input  logic [pcore_pipe_pkg::REG_AW-1:0]   rs_addr_i,
    output logic [pcore_isa_pkg::XLEN-1:0]      rs_data_o
);

    import pcore_isa_pkg::*;
    import pcore_pipe_pkg::*;

    localparam int unsigned NREG = 2 ** REG_AW;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NREG-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Value being written this cycle wins over the stored one
    always_comb begin
        if (rs_addr_i == '0) begin
            rs_data_o = '0;
        end else if (wr_i && (wr_addr_i == rs_addr_i)) begin
            rs_data_o = wr_data_i;
        end else begin
            rs_data_o = regs[rs_addr_i];
        end
    end

endmodule : reg_file

`default_nettype wire

//--- writeback/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  logic                                wb_valid_i,
    input  pcore_pipe_pkg::rd_wrb_sel_e         wb_sel_i,
    input  logic [pcore_pipe_pkg::REG_AW-1:0]   wb_rd_addr_i,
    input  logic                                wb_is_store_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      alu_result_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      pc_next_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      dmem_rdata_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      csr_rdata_i,

    // Destination write request, also used for forwarding
    output logic                                rd_wr_o,
    output logic [pcore_pipe_pkg::REG_AW-1:0]   rd_addr_o,
    output logic [pcore_isa_pkg::XLEN-1:0]      rd_data_o
);

    import pcore_pipe_pkg::*;

    // Destination value mux
    always_comb begin
        case (wb_sel_i)
            RD_WRB_ALU    : rd_data_o = alu_result_i;
            RD_WRB_INC_PC : rd_data_o = pc_next_i;
            RD_WRB_DMEM   : rd_data_o = dmem_rdata_i;
            RD_WRB_CSR    : rd_data_o = csr_rdata_i;
            default       : rd_data_o = '0;
        endcase
    end

    // No write for x0 or for a store
    assign rd_wr_o   = wb_valid_i && (wb_rd_addr_i != '0) && !wb_is_store_i;
    assign rd_addr_o = wb_rd_addr_i;

endmodule : writeback

`default_nettype wire

//--- hw/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                we_i,
    input  logic [pcore_isa_pkg::CSR_AW-1:0]    addr_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]      wdata_i,
    output logic [pcore_isa_pkg::XLEN-1:0]      rdata_o
);

    import pcore_isa_pkg::*;

    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] old_value;

    // Unknown addresses read as zero
    always_comb begin
        case (addr_i)
            CSR_MSCRATCH : old_value = mscratch_q;
            CSR_MTVEC    : old_value = mtvec_q;
            CSR_MEPC     : old_value = mepc_q;
            default      : old_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
        end else if (we_i) begin
            case (addr_i)
                CSR_MSCRATCH : mscratch_q <= wdata_i;
                CSR_MTVEC    : mtvec_q    <= wdata_i;
                CSR_MEPC     : mepc_q     <= wdata_i;
                default      : ;
            endcase
        end
    end

    // Swap, old value captured on the same edge as the write
    always_ff @(posedge clk) begin
        if (we_i) begin
            rdata_o <= old_value;
        end
    end

endmodule : csr_file

`default_nettype wire

//--- hw/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int unsigned DMEM_DEPTH = 256
) (
    input  logic                               clk,
    input  logic                               we_i,
    input  logic [$clog2(DMEM_DEPTH)-1:0]      addr_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]     wdata_i,
    output logic [pcore_isa_pkg::XLEN-1:0]     rdata_o
);

    import pcore_isa_pkg::*;

    logic [XLEN-1:0] mem [DMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // Read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule : data_mem

`default_nettype wire

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int unsigned DMEM_DEPTH = 256
) (
    input  logic                                     clk,
    input  logic                                     rst_n_i,

    // Issue side, four-phase req/ack
    input  logic                                     op_req_i,
    output logic                                     op_ack_o,
    input  pcore_isa_pkg::exe_op_e                   op_code_i,
    input  logic [pcore_pipe_pkg::REG_AW-1:0]        rd_addr_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]           alu_result_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]           pc_next_i,
    input  logic [pcore_isa_pkg::XLEN-1:0]           wr_data_i,
    input  logic [pcore_isa_pkg::CSR_AW-1:0]         csr_addr_i,

    // Data memory
    output logic                                     dmem_we_o,
    output logic [$clog2(DMEM_DEPTH)-1:0]            dmem_addr_o,
    output logic [pcore_isa_pkg::XLEN-1:0]           dmem_wdata_o,

    // CSR file
    output logic                                     csr_we_o,
    output logic [pcore_isa_pkg::CSR_AW-1:0]         csr_addr_o,
    output logic [pcore_isa_pkg::XLEN-1:0]           csr_wdata_o,

    // Writeback
    output logic                                     wb_valid_o,
    output pcore_pipe_pkg::rd_wrb_sel_e              wb_sel_o,
    output logic [pcore_pipe_pkg::REG_AW-1:0]        wb_rd_addr_o,
    output logic [pcore_isa_pkg::XLEN-1:0]           wb_alu_result_o,
    output logic [pcore_isa_pkg::XLEN-1:0]           wb_pc_next_o,
    output logic                                     wb_is_store_o
);

    import pcore_isa_pkg::*;
    import pcore_pipe_pkg::*;

    localparam int unsigned DMEM_AW = $clog2(DMEM_DEPTH);

    logic                 capture;
    logic                 op_vld_q;
    exe_op_e              op_code_q;
    logic [REG_AW-1:0]    op_rd_q;
    logic [XLEN-1:0]      op_alu_q;
    logic [XLEN-1:0]      op_pc_next_q;
    logic [XLEN-1:0]      op_wdata_q;
    logic [CSR_AW-1:0]    op_csr_addr_q;
    rd_wrb_sel_e          dec_sel;

    // New request seen while the previous one is fully retired
    assign capture = op_req_i && !op_ack_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op_ack_o   <= 1'b0;
            op_vld_q   <= 1'b0;
            wb_valid_o <= 1'b0;
        end else begin
            op_vld_q   <= capture;
            wb_valid_o <= op_vld_q;
            if (capture) begin
                op_ack_o <= 1'b1;
            end else if (!op_req_i) begin
                op_ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            op_code_q     <= op_code_i;
            op_rd_q       <= rd_addr_i;
            op_alu_q      <= alu_result_i;
            op_pc_next_q  <= pc_next_i;
            op_wdata_q    <= wr_data_i;
            op_csr_addr_q <= csr_addr_i;
        end
    end

    always_comb begin
        case (op_code_q)
            OP_LINK  : dec_sel = RD_WRB_INC_PC;
            OP_LOAD  : dec_sel = RD_WRB_DMEM;
            OP_CSRRW : dec_sel = RD_WRB_CSR;
            default  : dec_sel = RD_WRB_ALU;
        endcase
    end

    // Word index of the ALU address, wraps with the memory size
    assign dmem_we_o    = op_vld_q && (op_code_q == OP_STORE);
    assign dmem_addr_o  = op_alu_q[DMEM_AW+1:2];
    assign dmem_wdata_o = op_wdata_q;

    assign csr_we_o    = op_vld_q && (op_code_q == OP_CSRRW);
    assign csr_addr_o  = op_csr_addr_q;
    assign csr_wdata_o = op_wdata_q;

    always_ff @(posedge clk) begin
        if (op_vld_q) begin
            wb_sel_o        <= dec_sel;
            wb_rd_addr_o    <= op_rd_q;
            wb_alu_result_o <= op_alu_q;
            wb_pc_next_o    <= op_pc_next_q;
            wb_is_store_o   <= (op_code_q == OP_STORE);
        end
    end

endmodule : mem_stage

`default_nettype wire

//--- common/pcore_pipe_pkg.sv
`default_nettype none

package pcore_pipe_pkg;

    // Register address width, 32 architectural registers
    parameter int unsigned REG_AW = 5;

    // Source of the value written to rd
    typedef enum logic [1:0] {
        RD_WRB_ALU    = 2'd0,
        RD_WRB_INC_PC = 2'd1,
        RD_WRB_DMEM   = 2'd2,
        RD_WRB_CSR    = 2'd3
    } rd_wrb_sel_e;

endpackage : pcore_pipe_pkg

`default_nettype wire

//--- common/pcore_isa_pkg.sv
`default_nettype none

package pcore_isa_pkg;

    // Data path width
    parameter int unsigned XLEN = 32;

    // Operations handed to the back end by the issue logic
    typedef enum logic [2:0] {
        OP_ALU   = 3'd0,
        OP_LINK  = 3'd1,
        OP_LOAD  = 3'd2,
        OP_STORE = 3'd3,
        OP_CSRRW = 3'd4
    } exe_op_e;

    // Width of a CSR address
    parameter int unsigned CSR_AW = 12;

    // Machine mode CSRs implemented by the CSR file
    parameter logic [CSR_AW-1:0] CSR_MSCRATCH = 12'h340;
    parameter logic [CSR_AW-1:0] CSR_MTVEC    = 12'h305;
    parameter logic [CSR_AW-1:0] CSR_MEPC     = 12'h341;

endpackage : pcore_isa_pkg

`default_nettype wire
